/* Bender.yml */
package:
  name: dual_issue_cpu

sources:
  - cpu_pkg.sv
  - regfile.sv
  - operand_forward.sv
  - flag_select.sv
  - exec_lane.sv
  - hazard_unit.sv
  - branch_unit.sv
  - fetch_unit.sv
  - cpu.sv
  - target: test
    files:
      - tb_cpu.sv

/* all.f */
cpu_pkg.sv
regfile.sv
operand_forward.sv
flag_select.sv
exec_lane.sv
hazard_unit.sv
branch_unit.sv
fetch_unit.sv
cpu.sv
tb_cpu.sv

/* branch_unit.sv */
`default_nettype none

module branch_unit (
    input  wire                  clk,
    input  wire                  rst,
    input  wire cpu_pkg::op_t    op0,
    input  wire cpu_pkg::cond_t  cond0,
    input  wire cpu_pkg::addr_t  target0,
    input  wire cpu_pkg::addr_t  pc0,
    input  wire                  issue0,
    input  wire cpu_pkg::op_t    op1,
    input  wire cpu_pkg::cond_t  cond1,
    input  wire cpu_pkg::addr_t  target1,
    input  wire cpu_pkg::addr_t  pc1,
    input  wire                  issue1,
    input  wire                  n0,
    input  wire                  z0,
    input  wire                  v0,
    input  wire                  n1,
    input  wire                  z1,
    input  wire                  v1,
    input  wire                  flag_lane,
    output logic                 redirect,
    output cpu_pkg::addr_t       redirect_addr,
    output logic                 halted,
    output cpu_pkg::addr_t       halt_addr
);
    import cpu_pkg::*;

    logic fn;
    logic fz;
    logic fv;
    logic br0;
    logic br1;
    logic hlt0;
    logic hlt1;

    function automatic logic cond_holds(cond_t c, logic cn, logic cz, logic cv);
        case (c)
            COND_AL: return 1'b1;
            COND_EQ: return cz;
            COND_NE: return ~cz;
            COND_LT: return cn ^ cv;
            COND_LE: return cz | (cn ^ cv);
            default: return 1'b0;
        endcase
    endfunction

    // Flags of whichever lane set them last
    assign fn = flag_lane ? n1 : n0;
    assign fz = flag_lane ? z1 : z0;
    assign fv = flag_lane ? v1 : v0;

    assign br0  = issue0 && op0 == OP_B;
    assign br1  = issue1 && op1 == OP_B;
    assign hlt0 = issue0 && op0 == OP_HALT;
    assign hlt1 = issue1 && op1 == OP_HALT;

    // Oldest issuing branch decides
    assign redirect      = br0 ? cond_holds(cond0, fn, fz, fv)
                               : br1 && cond_holds(cond1, fn, fz, fv);
    assign redirect_addr = br0 ? target0 : target1;

    always_ff @(posedge clk) begin
        if (rst) begin
            halted <= 1'b0;
        end else if (hlt0 || hlt1) begin
            halted <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!halted && (hlt0 || hlt1)) begin
            halt_addr <= hlt0 ? pc0 : pc1;
        end
    end

    assert property (@(posedge clk) disable iff (rst) halted |=> halted)
        else $error("branch: halted dropped without reset");

endmodule

`default_nettype wire

/* cpu.sv */
`default_nettype none

module cpu (
    input  wire                  clk,
    input  wire                  rst,
    input  wire cpu_pkg::instr_t p0_im_data,
    input  wire cpu_pkg::instr_t p1_im_data,
    output cpu_pkg::addr_t       p0_im_addr,
    output cpu_pkg::addr_t       p1_im_addr,
    output logic                 im_en,
    output logic                 halted,
    output cpu_pkg::addr_t       halt_addr,
    output logic                 wb0_en,
    output cpu_pkg::reg_num_t    wb0_num,
    output cpu_pkg::data_t       wb0_data,
    output logic                 wb1_en,
    output cpu_pkg::reg_num_t    wb1_num,
    output cpu_pkg::data_t       wb1_data
);
    import cpu_pkg::*;

    // --------------------------------------------------
    // Decode pair
    // --------------------------------------------------
    instr_t   lane0_ir, lane1_ir;
    addr_t    lane0_pc, lane1_pc;
    logic     lane0_valid, lane1_valid;
    op_t      op0, op1;
    reg_num_t rd0, rn0, rm0, rn1, rm1;
    logic     writes_rd0;
    cond_t    cond0, cond1;
    addr_t    target0, target1;
    data_t    rn0_reg, rm0_reg, rn1_reg, rm1_reg;
    data_t    rn0_val, rm0_val, rn1_val, rm1_val;

    // --------------------------------------------------
    // Execute and control
    // --------------------------------------------------
    logic     ex0_write, ex1_write;
    reg_num_t ex0_num, ex1_num;
    data_t    ex0_data, ex1_data;
    logic     sets_flags_ex0, sets_flags_ex1;
    logic     n0, z0, v0, n1, z1, v1;
    logic     issue0, issue1, redirect, flag_lane;
    addr_t    redirect_addr;

    fetch_unit u_fetch (
        .clk(clk), .rst(rst), .p0_im_data(p0_im_data), .p1_im_data(p1_im_data),
        .fetch_next(im_en), .issue0(issue0), .issue1(issue1),
        .redirect(redirect), .redirect_addr(redirect_addr),
        .p0_im_addr(p0_im_addr), .p1_im_addr(p1_im_addr),
        .lane0_ir(lane0_ir), .lane1_ir(lane1_ir), .lane0_pc(lane0_pc), .lane1_pc(lane1_pc),
        .lane0_valid(lane0_valid), .lane1_valid(lane1_valid)
    );

    exec_lane u_lane0 (
        .clk(clk), .rst(rst), .ir(lane0_ir), .valid(lane0_valid), .issue(issue0),
        .rn_val(rn0_val), .rm_val(rm0_val),
        .op(op0), .rd(rd0), .rn(rn0), .rm(rm0), .writes_rd(writes_rd0),
        .cond(cond0), .target(target0),
        .ex_write(ex0_write), .ex_num(ex0_num), .ex_result(ex0_data),
        .sets_flags_ex(sets_flags_ex0), .n(n0), .z(z0), .v(v0),
        .wb_en(wb0_en), .wb_num(wb0_num), .wb_data(wb0_data)
    );

    // Lane 1's rd only matters through its own writeback
    exec_lane u_lane1 (
        .clk(clk), .rst(rst), .ir(lane1_ir), .valid(lane1_valid), .issue(issue1),
        .rn_val(rn1_val), .rm_val(rm1_val),
        .op(op1), .rd(), .rn(rn1), .rm(rm1), .writes_rd(),
        .cond(cond1), .target(target1),
        .ex_write(ex1_write), .ex_num(ex1_num), .ex_result(ex1_data),
        .sets_flags_ex(sets_flags_ex1), .n(n1), .z(z1), .v(v1),
        .wb_en(wb1_en), .wb_num(wb1_num), .wb_data(wb1_data)
    );

    regfile u_regfile (
        .clk(clk), .rst(rst),
        .rnum0(rn0), .rnum1(rm0), .rnum2(rn1), .rnum3(rm1),
        .we0(wb0_en), .wnum0(wb0_num), .wdata0(wb0_data),
        .we1(wb1_en), .wnum1(wb1_num), .wdata1(wb1_data),
        .rval0(rn0_reg), .rval1(rm0_reg), .rval2(rn1_reg), .rval3(rm1_reg)
    );

    // Bypass ports match the ex and wb wire names
    operand_forward u_fwd_rn0 (.*, .num(rn0), .reg_val(rn0_reg), .val(rn0_val));
    operand_forward u_fwd_rm0 (.*, .num(rm0), .reg_val(rm0_reg), .val(rm0_val));
    operand_forward u_fwd_rn1 (.*, .num(rn1), .reg_val(rn1_reg), .val(rn1_val));
    operand_forward u_fwd_rm1 (.*, .num(rm1), .reg_val(rm1_reg), .val(rm1_val));

    hazard_unit u_hazard (
        .clk(clk), .lane0_valid(lane0_valid), .lane1_valid(lane1_valid),
        .op0(op0), .op1(op1), .rd0(rd0), .writes_rd0(writes_rd0), .rn1(rn1), .rm1(rm1),
        .sets_flags_ex0(sets_flags_ex0), .sets_flags_ex1(sets_flags_ex1),
        .redirect(redirect), .halted(halted),
        .issue0(issue0), .issue1(issue1), .fetch_next(im_en)
    );

    branch_unit u_branch (
        .clk(clk), .rst(rst),
        .op0(op0), .cond0(cond0), .target0(target0), .pc0(lane0_pc), .issue0(issue0),
        .op1(op1), .cond1(cond1), .target1(target1), .pc1(lane1_pc), .issue1(issue1),
        .n0(n0), .z0(z0), .v0(v0), .n1(n1), .z1(z1), .v1(v1), .flag_lane(flag_lane),
        .redirect(redirect), .redirect_addr(redirect_addr),
        .halted(halted), .halt_addr(halt_addr)
    );

    flag_select u_flag_select (
        .clk(clk), .rst(rst), .set0(sets_flags_ex0), .set1(sets_flags_ex1),
        .flag_lane(flag_lane)
    );

endmodule

`default_nettype wire

/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    // --------------------------------------------------
    // Datapath widths
    // --------------------------------------------------
    typedef logic [15:0] data_t;
    typedef logic [7:0]  addr_t;
    typedef logic [2:0]  reg_num_t;
    typedef logic [15:0] instr_t;

    localparam int NUM_REGS = 8;

    // --------------------------------------------------
    // Instruction fields
    // --------------------------------------------------
    localparam int OP_MSB  = 15;
    localparam int OP_LSB  = 13;
    // Branch condition sits in the rd field
    localparam int RD_MSB  = 10;
    localparam int RD_LSB  = 8;
    localparam int RN_MSB  = 7;
    localparam int RN_LSB  = 5;
    localparam int RM_MSB  = 4;
    localparam int RM_LSB  = 2;
    // Also the branch target
    localparam int IMM_MSB = 7;
    localparam int IMM_LSB = 0;

    // Codes 5 and 6 are unused and decode as NOP
    typedef enum logic [2:0] {
        OP_NOP  = 3'd0,
        OP_MOVI = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_B    = 3'd4,
        OP_HALT = 3'd7
    } op_t;

    // Codes 5 to 7 are never taken
    typedef enum logic [2:0] {
        COND_AL = 3'd0,
        COND_EQ = 3'd1,
        COND_NE = 3'd2,
        COND_LT = 3'd3,
        COND_LE = 3'd4
    } cond_t;

endpackage

`default_nettype wire

/* exec_lane.sv */
`default_nettype none

module exec_lane (
    input  wire                    clk,
    input  wire                    rst,
    input  wire cpu_pkg::instr_t   ir,
    input  wire                    valid,
    input  wire                    issue,
    input  wire cpu_pkg::data_t    rn_val,
    input  wire cpu_pkg::data_t    rm_val,
    output cpu_pkg::op_t           op,
    output cpu_pkg::reg_num_t      rd,
    output cpu_pkg::reg_num_t      rn,
    output cpu_pkg::reg_num_t      rm,
    output logic                   writes_rd,
    output cpu_pkg::cond_t         cond,
    output cpu_pkg::addr_t         target,
    output logic                   ex_write,
    output cpu_pkg::reg_num_t      ex_num,
    output cpu_pkg::data_t         ex_result,
    output logic                   sets_flags_ex,
    output logic                   n,
    output logic                   z,
    output logic                   v,
    output logic                   wb_en,
    output cpu_pkg::reg_num_t      wb_num,
    output cpu_pkg::data_t         wb_data
);
    import cpu_pkg::*;

    op_t   ex_op;
    data_t ex_a;
    data_t ex_b;
    data_t b_eff;
    data_t imm_sext;

    // --------------------------------------------------
    // Decode
    // --------------------------------------------------
    always_comb begin
        op = OP_NOP;
        if (valid) begin
            case (ir[OP_MSB:OP_LSB])
                OP_MOVI, OP_ADD, OP_SUB, OP_B, OP_HALT: op = op_t'(ir[OP_MSB:OP_LSB]);
                default: op = OP_NOP;
            endcase
        end
    end

    assign rd        = ir[RD_MSB:RD_LSB];
    assign rn        = ir[RN_MSB:RN_LSB];
    assign rm        = ir[RM_MSB:RM_LSB];
    assign cond      = cond_t'(ir[RD_MSB:RD_LSB]);
    assign target    = ir[IMM_MSB:IMM_LSB];
    assign imm_sext  = {{8{ir[IMM_MSB]}}, ir[IMM_MSB:IMM_LSB]};
    assign writes_rd = (op == OP_MOVI) || (op == OP_ADD) || (op == OP_SUB);

    // --------------------------------------------------
    // Execute
    // --------------------------------------------------
    // Only register-writing work enters execute
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_op <= OP_NOP;
        end else begin
            ex_op <= (issue && writes_rd) ? op : OP_NOP;
        end
    end

    always_ff @(posedge clk) begin
        ex_num <= rd;
        ex_a   <= (op == OP_MOVI) ? imm_sext : rn_val;
        ex_b   <= rm_val;
    end

    assign sets_flags_ex = (ex_op == OP_ADD) || (ex_op == OP_SUB);
    assign ex_write      = sets_flags_ex || (ex_op == OP_MOVI);

    // SUB as a + ~b + 1
    assign b_eff     = (ex_op == OP_SUB) ? ~ex_b : ex_b;
    assign ex_result = (ex_op == OP_MOVI) ? ex_a : ex_a + b_eff + {15'd0, ex_op == OP_SUB};

    always_ff @(posedge clk) begin
        if (rst) begin
            n <= 1'b0;
            z <= 1'b0;
            v <= 1'b0;
        end else if (sets_flags_ex) begin
            n <= ex_result[15];
            z <= (ex_result == '0);
            // Signed overflow
            v <= (ex_a[15] == b_eff[15]) && (ex_result[15] != ex_a[15]);
        end
    end

    // --------------------------------------------------
    // Writeback
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= ex_write;
        end
    end

    always_ff @(posedge clk) begin
        wb_num  <= ex_num;
        wb_data <= ex_result;
    end

endmodule

`default_nettype wire

/* fetch_unit.sv */
`default_nettype none

module fetch_unit (
    input  wire                  clk,
    input  wire                  rst,
    input  wire cpu_pkg::instr_t p0_im_data,
    input  wire cpu_pkg::instr_t p1_im_data,
    input  wire                  fetch_next,
    input  wire                  issue0,
    input  wire                  issue1,
    input  wire                  redirect,
    input  wire cpu_pkg::addr_t  redirect_addr,
    output cpu_pkg::addr_t       p0_im_addr,
    output cpu_pkg::addr_t       p1_im_addr,
    output cpu_pkg::instr_t      lane0_ir,
    output cpu_pkg::instr_t      lane1_ir,
    output cpu_pkg::addr_t       lane0_pc,
    output cpu_pkg::addr_t       lane1_pc,
    output logic                 lane0_valid,
    output logic                 lane1_valid
);
    import cpu_pkg::*;

    // pc keeps an odd redirect target until the pair arrives
    addr_t pc;
    addr_t pair_pc;

    assign p0_im_addr = {pc[7:1], 1'b0};
    assign p1_im_addr = {pc[7:1], 1'b1};
    assign lane0_pc   = pair_pc;
    assign lane1_pc   = {pair_pc[7:1], 1'b1};

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= '0;
            lane0_valid <= 1'b0;
            lane1_valid <= 1'b0;
        end else if (redirect) begin
            pc          <= redirect_addr;
            lane0_valid <= 1'b0;
            lane1_valid <= 1'b0;
        end else if (fetch_next) begin
            pc          <= p0_im_addr + 8'd2;
            // Skip the even word in front of an odd target
            lane0_valid <= ~pc[0];
            lane1_valid <= 1'b1;
        end else begin
            if (issue0) lane0_valid <= 1'b0;
            if (issue1) lane1_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_next) begin
            lane0_ir <= p0_im_data;
            lane1_ir <= p1_im_data;
            pair_pc  <= p0_im_addr;
        end
    end

    assert property (@(posedge clk) disable iff (rst) p0_im_addr[0] == 1'b0)
        else $error("fetch: odd pair address %0h", p0_im_addr);

endmodule

`default_nettype wire

/* flag_select.sv */
`default_nettype none

module flag_select (
    input  wire  clk,
    input  wire  rst,
    input  wire  set0,
    input  wire  set1,
    output logic flag_lane
);

    // Lane 1 is younger and wins when both set flags
    always_ff @(posedge clk) begin
        if (rst) begin
            flag_lane <= 1'b0;
        end else if (set1) begin
            flag_lane <= 1'b1;
        end else if (set0) begin
            flag_lane <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hazard_unit.sv */
`default_nettype none

module hazard_unit (
    input  wire                    clk,
    input  wire                    lane0_valid,
    input  wire                    lane1_valid,
    input  wire cpu_pkg::op_t      op0,
    input  wire cpu_pkg::op_t      op1,
    input  wire cpu_pkg::reg_num_t rd0,
    input  wire                    writes_rd0,
    input  wire cpu_pkg::reg_num_t rn1,
    input  wire cpu_pkg::reg_num_t rm1,
    input  wire                    sets_flags_ex0,
    input  wire                    sets_flags_ex1,
    input  wire                    redirect,
    input  wire                    halted,
    output logic                   issue0,
    output logic                   issue1,
    output logic                   fetch_next
);
    import cpu_pkg::*;

    logic flags_busy;
    logic alu0;
    logic lane0_done;
    logic raw1;
    logic hold1;
    logic kill1;
    logic halt_now;

    assign flags_busy = sets_flags_ex0 || sets_flags_ex1;
    assign alu0       = (op0 == OP_ADD) || (op0 == OP_SUB);

    // Branch waits for flags still in execute
    assign issue0     = lane0_valid && !halted && !(op0 == OP_B && flags_busy);
    assign lane0_done = !lane0_valid || issue0;

    // Lane 1 reading lane 0's result
    assign raw1 = lane0_valid && writes_rd0 && ((op1 == OP_ADD) || (op1 == OP_SUB))
                  && (rn1 == rd0 || rm1 == rd0);

    // A lane 0 branch goes alone, a taken one flushes lane 1 with the pair
    assign hold1 = raw1
                   || (op1 == OP_B && (flags_busy || (lane0_valid && alu0)))
                   || (lane0_valid && op0 == OP_B);
    assign kill1 = issue0 && op0 == OP_HALT;

    assign issue1   = lane1_valid && !halted && lane0_done && !hold1 && !kill1;
    assign halt_now = (issue0 && op0 == OP_HALT) || (issue1 && op1 == OP_HALT);

    assign fetch_next = !halted && !redirect && !halt_now && lane0_done
                        && (!lane1_valid || issue1 || kill1);

    // In-order issue across the pair
    assert property (@(posedge clk) issue1 |-> (!lane0_valid || issue0))
        else $error("hazard: lane 1 issued past a held lane 0");

endmodule

`default_nettype wire

/* operand_forward.sv */
`default_nettype none

module operand_forward (
    input  wire cpu_pkg::reg_num_t num,
    input  wire cpu_pkg::data_t    reg_val,
    input  wire                    ex1_write,
    input  wire cpu_pkg::reg_num_t ex1_num,
    input  wire cpu_pkg::data_t    ex1_data,
    input  wire                    ex0_write,
    input  wire cpu_pkg::reg_num_t ex0_num,
    input  wire cpu_pkg::data_t    ex0_data,
    input  wire                    wb1_en,
    input  wire cpu_pkg::reg_num_t wb1_num,
    input  wire cpu_pkg::data_t    wb1_data,
    input  wire                    wb0_en,
    input  wire cpu_pkg::reg_num_t wb0_num,
    input  wire cpu_pkg::data_t    wb0_data,
    output cpu_pkg::data_t         val
);
    import cpu_pkg::*;

    // Youngest producer first
    always_comb begin
        if (ex1_write && ex1_num == num) val = ex1_data;
        else if (ex0_write && ex0_num == num) val = ex0_data;
        else if (wb1_en && wb1_num == num) val = wb1_data;
        else if (wb0_en && wb0_num == num) val = wb0_data;
        else val = reg_val;
    end

endmodule

`default_nettype wire

/* regfile.sv */
`default_nettype none

module regfile (
    input  wire                    clk,
    input  wire                    rst,
    input  wire cpu_pkg::reg_num_t rnum0,
    input  wire cpu_pkg::reg_num_t rnum1,
    input  wire cpu_pkg::reg_num_t rnum2,
    input  wire cpu_pkg::reg_num_t rnum3,
    input  wire                    we0,
    input  wire cpu_pkg::reg_num_t wnum0,
    input  wire cpu_pkg::data_t    wdata0,
    input  wire                    we1,
    input  wire cpu_pkg::reg_num_t wnum1,
    input  wire cpu_pkg::data_t    wdata1,
    output cpu_pkg::data_t         rval0,
    output cpu_pkg::data_t         rval1,
    output cpu_pkg::data_t         rval2,
    output cpu_pkg::data_t         rval3
);
    import cpu_pkg::*;

    data_t regs [NUM_REGS];

    assign rval0 = regs[rnum0];
    assign rval1 = regs[rnum1];
    assign rval2 = regs[rnum2];
    assign rval3 = regs[rnum3];

    // Lane 1 is younger, so its write lands last
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we0) regs[wnum0] <= wdata0;
            if (we1) regs[wnum1] <= wdata1;
        end
    end

endmodule

`default_nettype wire

/* tb_cpu.sv */
`default_nettype none

module tb_cpu;
    timeunit 1ns;
    timeprecision 100ps;

    import cpu_pkg::*;

    localparam int          CLK_PERIOD      = 20;
    localparam int          RESET_CYCLES    = 8;
    localparam int          CYCLES_PER_WORD = 40;
    localparam int          DRAIN_CYCLES    = 4;
    localparam int          MEM_WORDS       = 256;
    localparam int unsigned SEED            = 32'h80fa_18f8;

    logic     clk = 1'b0;
    logic     rst = 1'b1;
    instr_t   p0_im_data;
    instr_t   p1_im_data;
    addr_t    p0_im_addr;
    addr_t    p1_im_addr;
    logic     im_en;
    logic     halted;
    addr_t    halt_addr;
    logic     wb0_en;
    reg_num_t wb0_num;
    data_t    wb0_data;
    logic     wb1_en;
    reg_num_t wb1_num;
    data_t    wb1_data;

    // Program image and per-word test section
    instr_t   imem [MEM_WORDS];
    int       word_sect [MEM_WORDS];
    int       prog_words = 0;

    // Expected retire trace in program order
    reg_num_t exp_num [2 * MEM_WORDS];
    data_t    exp_data [2 * MEM_WORDS];
    int       exp_sect [2 * MEM_WORDS];
    int       exp_count = 0;
    addr_t    exp_halt;

    int       wr_idx = 0;
    int       value_errors = 0;
    int       other_errors = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    assign p0_im_data = imem[p0_im_addr];
    assign p1_im_data = imem[p1_im_addr];

    cpu u_cpu (
        .clk(clk), .rst(rst), .p0_im_data(p0_im_data), .p1_im_data(p1_im_data),
        .p0_im_addr(p0_im_addr), .p1_im_addr(p1_im_addr), .im_en(im_en),
        .halted(halted), .halt_addr(halt_addr),
        .wb0_en(wb0_en), .wb0_num(wb0_num), .wb0_data(wb0_data),
        .wb1_en(wb1_en), .wb1_num(wb1_num), .wb1_data(wb1_data)
    );

    // --------------------------------------------------
    // Instruction encoding
    // --------------------------------------------------
    function automatic instr_t movi(reg_num_t rd, logic [7:0] imm);
        return {OP_MOVI, 2'b00, rd, imm};
    endfunction

    function automatic instr_t alu(op_t op, reg_num_t rd, reg_num_t rn, reg_num_t rm);
        return {op, 2'b00, rd, rn, rm, 2'b00};
    endfunction

    function automatic instr_t branch(cond_t c, addr_t target);
        return {OP_B, 2'b00, c, target};
    endfunction

    function automatic logic [7:0] rand_imm();
        return 8'($urandom());
    endfunction

    function automatic string section_name(int s);
        case (s)
            0: return "independent";
            1: return "dependency";
            2: return "same_register";
            3: return "branch";
            4: return "halt";
            default: return "stray";
        endcase
    endfunction

    task automatic place(int a, instr_t w, int s);
        imem[a]      = w;
        word_sect[a] = s;
        if (a + 1 > prog_words) begin
            prog_words = a + 1;
        end
    endtask

    // --------------------------------------------------
    // Program
    // --------------------------------------------------
    task automatic build_program();
        logic [7:0] x;
        logic [7:0] d;
        for (int a = 0; a < MEM_WORDS; a++) begin
            // Stray fetches land on a HALT tagged with its own address
            imem[a]      = {OP_HALT, 5'd0, 8'(a)};
            word_sect[a] = 5;
        end
        place(0, movi(3'd1, rand_imm()), 0);
        place(1, movi(3'd2, rand_imm()), 0);
        place(2, movi(3'd3, rand_imm()), 0);
        place(3, movi(3'd4, rand_imm()), 0);
        place(4, alu(OP_ADD, 3'd5, 3'd1, 3'd2), 0);
        place(5, alu(OP_ADD, 3'd6, 3'd3, 3'd4), 0);
        // Across pairs, then inside a pair
        place(6, alu(OP_ADD, 3'd7, 3'd5, 3'd6), 1);
        place(7, alu(OP_ADD, 3'd1, 3'd7, 3'd5), 1);
        place(8, alu(OP_SUB, 3'd2, 3'd1, 3'd7), 1);
        place(9, alu(OP_ADD, 3'd3, 3'd2, 3'd2), 1);
        place(10, movi(3'd4, rand_imm()), 1);
        place(11, alu(OP_ADD, 3'd5, 3'd4, 3'd3), 1);
        // Same destination in both lanes
        place(12, movi(3'd0, rand_imm()), 2);
        place(13, movi(3'd0, rand_imm()), 2);
        place(14, movi(3'd6, rand_imm()), 2);
        place(15, movi(3'd6, rand_imm()), 2);
        place(16, alu(OP_ADD, 3'd7, 3'd6, 3'd6), 2);
        place(17, 16'h0000, 2);
        place(18, 16'h0000, 2);
        place(19, 16'h0000, 2);
        // r0 is read back from the register file here
        place(20, alu(OP_ADD, 3'd1, 3'd0, 3'd0), 2);
        place(21, alu(OP_ADD, 3'd2, 3'd0, 3'd1), 2);
        // r1 == r2, r3 above them, so SUBs give zero, negative, positive
        x = 8'($urandom_range(63, 0));
        d = 8'($urandom_range(63, 1));
        place(22, movi(3'd1, x), 3);
        place(23, movi(3'd2, x), 3);
        place(24, movi(3'd3, x + d), 3);
        place(25, alu(OP_SUB, 3'd0, 3'd1, 3'd2), 3);
        place(26, branch(COND_EQ, 8'd29), 3);
        place(27, movi(3'd7, rand_imm()), 3);
        place(28, movi(3'd7, rand_imm()), 3);
        place(29, branch(COND_NE, 8'd27), 3);
        place(30, alu(OP_SUB, 3'd0, 3'd1, 3'd3), 3);
        place(31, branch(COND_LE, 8'd34), 3);
        place(32, movi(3'd7, rand_imm()), 3);
        place(33, movi(3'd7, rand_imm()), 3);
        place(34, branch(COND_LT, 8'd37), 3);
        place(35, movi(3'd7, rand_imm()), 3);
        place(36, movi(3'd7, rand_imm()), 3);
        place(37, branch(COND_EQ, 8'd35), 3);
        place(38, alu(OP_SUB, 3'd0, 3'd3, 3'd1), 3);
        place(39, branch(COND_LT, 8'd36), 3);
        place(40, branch(COND_LE, 8'd35), 3);
        place(41, alu(OP_SUB, 3'd0, 3'd1, 3'd2), 3);
        place(42, branch(COND_LE, 8'd44), 3);
        place(43, movi(3'd7, rand_imm()), 3);
        // Both lanes set flags, lane 1 result is negative
        place(44, alu(OP_SUB, 3'd0, 3'd1, 3'd2), 3);
        place(45, alu(OP_SUB, 3'd0, 3'd1, 3'd3), 3);
        place(46, branch(COND_EQ, 8'd43), 3);
        place(47, branch(COND_NE, 8'd49), 3);
        place(48, movi(3'd7, rand_imm()), 3);
        place(49, branch(COND_AL, 8'd52), 3);
        place(50, movi(3'd7, rand_imm()), 3);
        place(51, movi(3'd7, rand_imm()), 3);
        place(52, movi(3'd5, rand_imm()), 4);
        place(53, alu(OP_ADD, 3'd6, 3'd5, 3'd5), 4);
        place(54, {OP_HALT, 13'd0}, 4);
        place(55, movi(3'd7, rand_imm()), 4);
    endtask

    // --------------------------------------------------
    // ISA reference model
    // --------------------------------------------------
    task automatic expect_write(ref data_t regs [NUM_REGS], input reg_num_t rd,
                                input data_t val, input int s);
        regs[rd]             = val;
        exp_num[exp_count]   = rd;
        exp_data[exp_count]  = val;
        exp_sect[exp_count]  = s;
        exp_count++;
    endtask

    task automatic run_reference();
        data_t  regs [NUM_REGS];
        logic   fn;
        logic   fz;
        logic   fv;
        logic   taken;
        logic   done;
        addr_t  pc;
        instr_t w;
        data_t  a;
        data_t  b;
        data_t  res;
        int     steps;
        for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] = '0;
        end
        fn    = 1'b0;
        fz    = 1'b0;
        fv    = 1'b0;
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 4 * MEM_WORDS) begin
            w     = imem[pc];
            a     = regs[w[7:5]];
            b     = regs[w[4:2]];
            taken = 1'b0;
            case (w[15:13])
                3'd1: expect_write(regs, w[10:8], {{8{w[7]}}, w[7:0]}, word_sect[pc]);
                3'd2, 3'd3: begin
                    res = (w[15:13] == 3'd2) ? a + b : a - b;
                    fn  = res[15];
                    fz  = (res == 16'd0);
                    if (w[15:13] == 3'd2) begin
                        fv = (a[15] == b[15]) && (res[15] != a[15]);
                    end else begin
                        fv = (a[15] != b[15]) && (res[15] != a[15]);
                    end
                    expect_write(regs, w[10:8], res, word_sect[pc]);
                end
                3'd4: begin
                    case (w[10:8])
                        3'd0: taken = 1'b1;
                        3'd1: taken = fz;
                        3'd2: taken = !fz;
                        3'd3: taken = fn ^ fv;
                        3'd4: taken = fz || (fn ^ fv);
                        default: taken = 1'b0;
                    endcase
                end
                3'd7: begin
                    exp_halt = pc;
                    done     = 1'b1;
                end
                default: ;
            endcase
            pc = taken ? w[7:0] : pc + 8'd1;
            steps++;
        end
    endtask

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    function automatic logic write_matches(int idx, reg_num_t num, data_t data);
        return idx < exp_count && exp_num[idx] == num && exp_data[idx] == data;
    endfunction

    task automatic report_write(int lane, int idx, reg_num_t num, data_t data);
        if (idx >= exp_count) begin
            other_errors++;
            $display("Lane %0d wrote r%0d=%h after the last expected write", lane, num, data);
        end else begin
            value_errors++;
            $display("CHECK FAILED %s: lane %0d expected r%0d=%h, actual r%0d=%h",
                     section_name(exp_sect[idx]), lane, exp_num[idx], exp_data[idx],
                     num, data);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            wr_idx <= 0;
        end else begin
            wr_idx <= wr_idx + int'(wb0_en) + int'(wb1_en);
        end
    end

    // Lane 0 retires ahead of lane 1 in the same cycle
    wb0_check: assert property (@(posedge clk) disable iff (rst)
        wb0_en |-> write_matches(wr_idx, wb0_num, wb0_data))
        else report_write(0, $sampled(wr_idx), $sampled(wb0_num), $sampled(wb0_data));

    wb1_check: assert property (@(posedge clk) disable iff (rst)
        wb1_en |-> write_matches(wr_idx + int'(wb0_en), wb1_num, wb1_data))
        else report_write(1, $sampled(wr_idx) + int'($sampled(wb0_en)),
                          $sampled(wb1_num), $sampled(wb1_data));

    halt_addr_check: assert property (@(posedge clk) disable iff (rst)
        $rose(halted) |-> halt_addr == exp_halt)
        else begin
            value_errors++;
            $display("CHECK FAILED halt: expected halt_addr=%h, actual halt_addr=%h",
                     exp_halt, $sampled(halt_addr));
        end

    fetch_stop_check: assert property (@(posedge clk) disable iff (rst)
        halted |-> !im_en)
        else begin
            other_errors++;
            $display("im_en was high while the CPU was halted");
        end

    task automatic report_and_finish();
        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    // --------------------------------------------------
    // Run control
    // --------------------------------------------------
    initial begin
        void'($urandom(SEED));
        build_program();
        run_reference();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        while (halted !== 1'b1) begin
            @(posedge clk);
        end
        // Older instructions still draining through writeback
        repeat (DRAIN_CYCLES) @(posedge clk);
        if (wr_idx != exp_count) begin
            other_errors++;
            $display("Only %0d of %0d expected register writes retired", wr_idx, exp_count);
        end
        report_and_finish();
    end

    initial begin
        wait (prog_words > 0);
        repeat (RESET_CYCLES + prog_words * CYCLES_PER_WORD) @(posedge clk);
        other_errors++;
        $display("Watchdog expired: the CPU did not halt within %0d cycles",
                 prog_words * CYCLES_PER_WORD);
        report_and_finish();
    end

endmodule

`default_nettype wire
